/* build.f */
hdl/mem_bus_pkg.sv
hdl/cpu_port_pkg.sv
hdl/port_arbiter.sv
hdl/byte_sequencer.sv
hdl/byte_ram.sv
hdl/mem_ctrl_top.sv
testbench/mem_ctrl_assertions.sv
testbench/tb_clock.sv
testbench/tb_top.sv

/* hdl/byte_ram.sv */
`timescale 1ns/1ns

module byte_ram #(
  parameter int RAM_DEPTH = 1024
) (
  input  logic                   clk,
  input  logic                   rst,
  input  mem_bus_pkg::byte_req_t ram_req_i,
  output mem_bus_pkg::byte_rsp_t ram_rsp_o
);

  localparam int IDX_W  = $clog2(RAM_DEPTH);
  localparam int BYTE_W = mem_bus_pkg::BYTE_W;

  logic [BYTE_W-1:0] mem [RAM_DEPTH];
  logic              ack_q;
  logic [BYTE_W-1:0] rdat_q;
  logic [IDX_W-1:0]  idx;
  logic              hit;

  // upper address bits are ignored
  assign idx = ram_req_i.adr[IDX_W-1:0];
  // one ack per strobe, nothing new while the ack is out
  assign hit = ram_req_i.cyc & ram_req_i.stb & ~ack_q;

  always_ff @(posedge clk) begin
    if (!rst) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= hit;
    end
  end

  // write or read on the same edge that raises ack
  always_ff @(posedge clk) begin
    if (hit) begin
      if (ram_req_i.we) begin
        mem[idx] <= ram_req_i.dat;
      end else begin
        rdat_q <= mem[idx];
      end
    end
  end

  assign ram_rsp_o = '{ack: ack_q, dat: rdat_q};

endmodule

/* hdl/byte_sequencer.sv */
`timescale 1ns/1ns

module byte_sequencer #(
  parameter int ADDR_W = 10
) (
  input  logic                   clk,
  input  logic                   rst,
  input  cpu_port_pkg::cpu_req_t seq_req_i,
  input  mem_bus_pkg::byte_rsp_t ram_rsp_i,
  output cpu_port_pkg::cpu_rsp_t seq_rsp_o,
  output mem_bus_pkg::byte_req_t ram_req_o
);

  localparam int LANE_W = mem_bus_pkg::LANE_IDX_W;
  localparam int BYTE_W = mem_bus_pkg::BYTE_W;
  localparam int WORD_W = cpu_port_pkg::WORD_W;
  localparam int PAD_W  = mem_bus_pkg::ADR_MAX_W - ADDR_W;

  // control state
  logic              busy_q;
  logic              ack_q;
  logic [LANE_W-1:0] cnt_q;

  // request held for the whole access
  logic [LANE_W-1:0] last_q;
  logic              we_q;
  logic [ADDR_W-1:0] adr_q;
  logic [WORD_W-1:0] wdat_q;
  logic [WORD_W-1:0] rdat_q;

  logic              start;
  logic              byte_done;
  logic              final_byte;

  // new request only once the previous ack has been seen
  assign start      = ~busy_q & ~ack_q & seq_req_i.cyc & seq_req_i.stb;
  assign byte_done  = busy_q & ram_rsp_i.ack;
  // size value is the last byte index
  assign final_byte = byte_done & (cnt_q == last_q);

  always_ff @(posedge clk) begin
    if (!rst) begin
      busy_q <= 1'b0;
      ack_q  <= 1'b0;
      cnt_q  <= '0;
    end else begin
      // ack goes out the cycle after the last byte ack
      ack_q <= final_byte;
      if (start) begin
        busy_q <= 1'b1;
        cnt_q  <= '0;
      end else if (final_byte) begin
        busy_q <= 1'b0;
      end else if (byte_done) begin
        cnt_q <= cnt_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      adr_q  <= seq_req_i.adr[ADDR_W-1:0];
      wdat_q <= seq_req_i.dat;
      we_q   <= seq_req_i.we;
      last_q <= seq_req_i.size;
      // lanes above the access size read as zero
      rdat_q <= '0;
    end else if (byte_done) begin
      // next byte at the next address
      adr_q <= adr_q + 1'b1;
      if (!we_q) begin
        // little endian, byte n goes to lane n
        rdat_q[cnt_q*BYTE_W +: BYTE_W] <= ram_rsp_i.dat;
      end
    end
  end

  // stb stays up across the ack, the RAM re-arms once its ack clears
  // so every byte cycle is two clocks
  always_comb begin
    ram_req_o = '0;
    if (busy_q) begin
      ram_req_o.cyc = 1'b1;
      ram_req_o.stb = 1'b1;
      ram_req_o.we  = we_q;
      ram_req_o.adr = {{PAD_W{1'b0}}, adr_q};
      // write data lowest byte first
      ram_req_o.dat = wdat_q[cnt_q*BYTE_W +: BYTE_W];
    end
  end

  // writes return zero data
  assign seq_rsp_o = '{ack: ack_q, dat: rdat_q};

endmodule

/* hdl/cpu_port_pkg.sv */
package cpu_port_pkg;

  // processor data word
  localparam int WORD_W = 32;

  // processor address width
  localparam int CPU_ADR_W = 32;

  // classic wishbone request from a processor port
  typedef struct packed {
    logic                   cyc;
    logic                   stb;
    logic                   we;
    logic [CPU_ADR_W-1:0]   adr;
    logic [WORD_W-1:0]      dat;
    mem_bus_pkg::acc_size_e size;
  } cpu_req_t;

  // response to a processor port
  typedef struct packed {
    logic              ack;
    logic [WORD_W-1:0] dat;
  } cpu_rsp_t;

endpackage

/* hdl/mem_bus_pkg.sv */
package mem_bus_pkg;

  // width of one RAM data lane
  localparam int BYTE_W = 8;

  // byte bus carries the widest address, the RAM keeps the low bits
  localparam int ADR_MAX_W = 32;

  // bits needed to count the byte lanes of a word
  localparam int LANE_IDX_W = 2;

  // access size, encoded as the index of the last byte
  typedef enum logic [LANE_IDX_W-1:0] {
    size_byte = 2'd0,
    size_half = 2'd1,
    size_word = 2'd3
  } acc_size_e;

  // byte bus, sequencer to RAM
  typedef struct packed {
    logic                 cyc;
    logic                 stb;
    logic                 we;
    logic [ADR_MAX_W-1:0] adr;
    logic [BYTE_W-1:0]    dat;
  } byte_req_t;

  // byte bus, RAM back to sequencer
  typedef struct packed {
    logic              ack;
    logic [BYTE_W-1:0] dat;
  } byte_rsp_t;

endpackage

/* hdl/mem_ctrl_top.sv */
`timescale 1ns/1ns

module mem_ctrl_top #(
  parameter int ADDR_W    = 10,
  parameter int RAM_DEPTH = 2 ** ADDR_W
) (
  input  logic                   clk,
  input  logic                   rst,
  input  cpu_port_pkg::cpu_req_t fetch_req_i,
  input  cpu_port_pkg::cpu_req_t data_req_i,
  output cpu_port_pkg::cpu_rsp_t fetch_rsp_o,
  output cpu_port_pkg::cpu_rsp_t data_rsp_o
);

  // arbiter to sequencer
  cpu_port_pkg::cpu_req_t seq_req;
  cpu_port_pkg::cpu_rsp_t seq_rsp;

  // sequencer to RAM
  mem_bus_pkg::byte_req_t ram_req;
  mem_bus_pkg::byte_rsp_t ram_rsp;

  // fetch and data share one sequencer
  port_arbiter arb_i (
    .clk         (clk),
    .rst         (rst),
    .fetch_req_i (fetch_req_i),
    .data_req_i  (data_req_i),
    .seq_rsp_i   (seq_rsp),
    .fetch_rsp_o (fetch_rsp_o),
    .data_rsp_o  (data_rsp_o),
    .seq_req_o   (seq_req)
  );

  // word access split into byte cycles
  byte_sequencer #(
    .ADDR_W (ADDR_W)
  ) seq_i (
    .clk       (clk),
    .rst       (rst),
    .seq_req_i (seq_req),
    .ram_rsp_i (ram_rsp),
    .seq_rsp_o (seq_rsp),
    .ram_req_o (ram_req)
  );

  byte_ram #(
    .RAM_DEPTH (RAM_DEPTH)
  ) ram_i (
    .clk       (clk),
    .rst       (rst),
    .ram_req_i (ram_req),
    .ram_rsp_o (ram_rsp)
  );

endmodule

/* hdl/port_arbiter.sv */
`timescale 1ns/1ns

module port_arbiter (
  input  logic                   clk,
  input  logic                   rst,
  input  cpu_port_pkg::cpu_req_t fetch_req_i,
  input  cpu_port_pkg::cpu_req_t data_req_i,
  input  cpu_port_pkg::cpu_rsp_t seq_rsp_i,
  output cpu_port_pkg::cpu_rsp_t fetch_rsp_o,
  output cpu_port_pkg::cpu_rsp_t data_rsp_o,
  output cpu_port_pkg::cpu_req_t seq_req_o
);

  logic                            busy_q;
  // 1 = data port owns the sequencer
  logic                            grant_data_q;
  logic                            fetch_ack_q;
  logic                            data_ack_q;
  logic [cpu_port_pkg::WORD_W-1:0] rsp_dat_q;
  logic                            fetch_pend;
  logic                            data_pend;
  cpu_port_pkg::cpu_req_t          fetch_rd;

  // a port still holding stb in its ack cycle was already served
  assign fetch_pend = fetch_req_i.cyc & fetch_req_i.stb & ~fetch_ack_q;
  assign data_pend  = data_req_i.cyc & data_req_i.stb & ~data_ack_q;

  // fetch is always a word read
  always_comb begin
    fetch_rd      = fetch_req_i;
    fetch_rd.we   = 1'b0;
    fetch_rd.size = mem_bus_pkg::size_word;
  end

  // request path runs from the registered grant
  always_comb begin
    seq_req_o = '0;
    if (busy_q) begin
      seq_req_o = grant_data_q ? data_req_i : fetch_rd;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst) begin
      busy_q       <= 1'b0;
      grant_data_q <= 1'b0;
      fetch_ack_q  <= 1'b0;
      data_ack_q   <= 1'b0;
    end else begin
      // port acks are single cycle pulses
      fetch_ack_q <= 1'b0;
      data_ack_q  <= 1'b0;
      if (!busy_q) begin
        // data port has priority
        if (data_pend) begin
          busy_q       <= 1'b1;
          grant_data_q <= 1'b1;
        end else if (fetch_pend) begin
          busy_q       <= 1'b1;
          grant_data_q <= 1'b0;
        end
      end else if (seq_rsp_i.ack) begin
        // hand the ack to the owner only, then go idle
        busy_q      <= 1'b0;
        fetch_ack_q <= ~grant_data_q;
        data_ack_q  <= grant_data_q;
      end
    end
  end

  // one read data register serves both ports
  always_ff @(posedge clk) begin
    if (busy_q && seq_rsp_i.ack) begin
      rsp_dat_q <= seq_rsp_i.dat;
    end
  end

  assign fetch_rsp_o = '{ack: fetch_ack_q, dat: rsp_dat_q};
  assign data_rsp_o  = '{ack: data_ack_q, dat: rsp_dat_q};

endmodule

/* run.sh */
#!/bin/sh
# build and run the memory controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -j 0 --top-module tb_top -f build.f -o tb_sim; then
  echo "verilator build failed"
  exit 1
fi

# assertion errors are counted by the testbench, keep running past the first one
out=$(./obj_dir/tb_sim +verilator+error+limit+1000)
status=$?
echo "$out"
if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "NO ERRORS"; then
  exit 0
fi
exit 1

/* testbench/mem_ctrl_assertions.sv */
`timescale 1ns/1ns

module mem_ctrl_assertions #(
  parameter int RAM_DEPTH = 1024
) (
  input logic                   clk,
  input logic                   rst,
  input cpu_port_pkg::cpu_req_t fetch_req_i,
  input cpu_port_pkg::cpu_req_t data_req_i,
  input cpu_port_pkg::cpu_rsp_t fetch_rsp_i,
  input cpu_port_pkg::cpu_rsp_t data_rsp_i
);

  localparam int IDX_W = $clog2(RAM_DEPTH);

  // bytes as the processor has written them
  logic [7:0]  shadow [RAM_DEPTH];
  int unsigned fail_cnt = 0;
  logic        seen_req_q;
  logic        data_first_q;
  logic        fetch_stb_q;
  logic        data_stb_q;
  logic        fetch_stb;
  logic        data_stb;

  assign fetch_stb = fetch_req_i.cyc & fetch_req_i.stb;
  assign data_stb  = data_req_i.cyc & data_req_i.stb;

  // little endian word from the shadow, lanes past size stay zero
  function automatic logic [31:0] expect_read(input logic [31:0] adr,
                                              input mem_bus_pkg::acc_size_e size);
    logic [31:0] w;
    w = '0;
    for (int n = 0; n < 4; n++) begin
      if (n <= int'(size)) begin
        w[n*8 +: 8] = shadow[IDX_W'(adr + n)];
      end
    end
    return w;
  endfunction

  // acked data writes, size bytes from adr upward, addresses wrap
  always_ff @(posedge clk) begin
    if (data_rsp_i.ack && data_req_i.we) begin
      shadow[IDX_W'(data_req_i.adr)] <= data_req_i.dat[7:0];
      if (data_req_i.size != mem_bus_pkg::size_byte) begin
        shadow[IDX_W'(data_req_i.adr + 1)] <= data_req_i.dat[15:8];
      end
      if (data_req_i.size == mem_bus_pkg::size_word) begin
        shadow[IDX_W'(data_req_i.adr + 2)] <= data_req_i.dat[23:16];
        shadow[IDX_W'(data_req_i.adr + 3)] <= data_req_i.dat[31:24];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst) begin
      seen_req_q   <= 1'b0;
      data_first_q <= 1'b0;
      fetch_stb_q  <= 1'b0;
      data_stb_q   <= 1'b0;
    end else begin
      seen_req_q  <= seen_req_q | fetch_stb | data_stb;
      fetch_stb_q <= fetch_stb;
      data_stb_q  <= data_stb;
      // both ports rise together on an idle arbiter, data owes the first ack
      if (data_stb && fetch_stb && !data_stb_q && !fetch_stb_q) begin
        data_first_q <= 1'b1;
      end else if (data_rsp_i.ack) begin
        data_first_q <= 1'b0;
      end
    end
  end

  // single cycle acks inside their own request, never on both ports
  a_ack_protocol: assert property (@(posedge clk) disable iff (!rst)
      !(data_rsp_i.ack && (!data_stb || $past(data_rsp_i.ack)))
      && !(fetch_rsp_i.ack && (!fetch_stb || $past(fetch_rsp_i.ack)))
      && !(data_rsp_i.ack && fetch_rsp_i.ack))
    else begin
      fail_cnt++;
      $error("MISMATCH t=%0t ack outside its request, too long, or on both ports", $time);
    end

  a_data_read: assert property (@(posedge clk) disable iff (!rst)
      data_rsp_i.ack && !data_req_i.we
      |-> data_rsp_i.dat == expect_read(data_req_i.adr, data_req_i.size))
    else begin
      fail_cnt++;
      $error("MISMATCH t=%0t data read adr %h got %h exp %h", $time, data_req_i.adr,
             data_rsp_i.dat, expect_read(data_req_i.adr, data_req_i.size));
    end

  // fetch sees the same word a data word read would
  a_fetch_read: assert property (@(posedge clk) disable iff (!rst)
      fetch_rsp_i.ack
      |-> fetch_rsp_i.dat == expect_read(fetch_req_i.adr, mem_bus_pkg::size_word))
    else begin
      fail_cnt++;
      $error("MISMATCH t=%0t fetch adr %h got %h exp %h", $time, fetch_req_i.adr,
             fetch_rsp_i.dat, expect_read(fetch_req_i.adr, mem_bus_pkg::size_word));
    end

  a_data_priority: assert property (@(posedge clk) disable iff (!rst)
      fetch_rsp_i.ack |-> !data_first_q)
    else begin
      fail_cnt++;
      $error("MISMATCH t=%0t fetch acked before the data request it tied with", $time);
    end

  a_quiet_after_reset: assert property (@(posedge clk) disable iff (!rst)
      !seen_req_q |-> !data_rsp_i.ack && !fetch_rsp_i.ack)
    else begin
      fail_cnt++;
      $error("MISMATCH t=%0t ack raised before any request", $time);
    end

endmodule

bind mem_ctrl_top mem_ctrl_assertions #(
  .RAM_DEPTH (RAM_DEPTH)
) chk_i (
  .clk         (clk),
  .rst         (rst),
  .fetch_req_i (fetch_req_i),
  .data_req_i  (data_req_i),
  .fetch_rsp_i (fetch_rsp_o),
  .data_rsp_i  (data_rsp_o)
);

/* testbench/tb_clock.sv */
`timescale 1ns/1ns

module tb_clock #(
  parameter int PERIOD_NS = 100
) (
  output logic clk_o
);

  // free running, starts low
  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

endmodule

/* testbench/tb_top.sv */
`timescale 1ns/1ns

module tb_top;

  localparam int ADDR_W    = 10;
  localparam int RAM_DEPTH = 2 ** ADDR_W;
  localparam int CLK_NS    = 100;
  // passes of each test loop
  localparam int N_LOOP    = 16;
  // fill writes plus 9 accesses per loop pass
  localparam int N_ACC     = RAM_DEPTH / 4 + 9 * N_LOOP;
  localparam int WDOG_CYC  = 20 * N_ACC + 200;

  logic                   clk;
  logic                   rst;
  cpu_port_pkg::cpu_req_t fetch_req;
  cpu_port_pkg::cpu_req_t data_req;
  cpu_port_pkg::cpu_rsp_t fetch_rsp;
  cpu_port_pkg::cpu_rsp_t data_rsp;
  logic [31:0]            rng_q;
  int unsigned            errs;

  tb_clock #(.PERIOD_NS(CLK_NS)) clk_gen_i (.clk_o(clk));

  mem_ctrl_top #(
    .ADDR_W    (ADDR_W),
    .RAM_DEPTH (RAM_DEPTH)
  ) dut_i (
    .clk         (clk),
    .rst         (rst),
    .fetch_req_i (fetch_req),
    .data_req_i  (data_req),
    .fetch_rsp_o (fetch_rsp),
    .data_rsp_o  (data_rsp)
  );

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    return x ^ (x << 5);
  endfunction

  // steps the generator state
  function automatic logic [31:0] rand_word();
    rng_q = xorshift(rng_q);
    return rng_q;
  endfunction

  // drive on the falling edge, hold through the ack cycle
  task automatic data_access(input logic we, input logic [31:0] adr, input logic [31:0] dat,
                             input mem_bus_pkg::acc_size_e size);
    data_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: dat, size: size};
    @(negedge clk);
    while (!data_rsp.ack) @(negedge clk);
    // ack is sampled on the next rising edge
    @(negedge clk);
    data_req = '0;
  endtask

  task automatic fetch_access(input logic [31:0] adr);
    fetch_req = '{cyc: 1'b1, stb: 1'b1, we: 1'b0, adr: adr, dat: 32'h0,
                  size: mem_bus_pkg::size_word};
    @(negedge clk);
    while (!fetch_rsp.ack) @(negedge clk);
    @(negedge clk);
    fetch_req = '0;
  endtask

  initial begin
    logic [31:0]            adr;
    logic [31:0]            r;
    mem_bus_pkg::acc_size_e size;
    rst       = 1'b0;
    fetch_req = '0;
    data_req  = '0;
    rng_q     = 32'hfdcf_f15f;
    // two rising edges in reset
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst = 1'b1;
    // a few idle cycles, acks must stay low
    repeat (3) @(negedge clk);

    // fill every word so all later reads hit written bytes
    for (int i = 0; i < RAM_DEPTH / 4; i++) begin
      data_access(1'b1, 4 * i, rand_word(), mem_bus_pkg::size_word);
    end
    // word write then word read back
    for (int i = 0; i < N_LOOP; i++) begin
      adr = rand_word() % RAM_DEPTH;
      data_access(1'b1, adr, rand_word(), mem_bus_pkg::size_word);
      data_access(1'b0, adr, 32'h0, mem_bus_pkg::size_word);
    end
    // narrow write, narrow read, then a word across the neighbours
    for (int i = 0; i < N_LOOP; i++) begin
      r    = rand_word();
      adr  = r % RAM_DEPTH;
      size = r[31] ? mem_bus_pkg::size_half : mem_bus_pkg::size_byte;
      data_access(1'b1, adr, rand_word(), size);
      data_access(1'b0, adr, 32'h0, size);
      data_access(1'b0, adr - 1, 32'h0, mem_bus_pkg::size_word);
    end
    // fetch and data read of one address
    for (int i = 0; i < N_LOOP; i++) begin
      adr = rand_word() % RAM_DEPTH;
      fetch_access(adr);
      data_access(1'b0, adr, 32'h0, mem_bus_pkg::size_word);
    end
    // both ports at once, overlapping bytes, idle cycle between passes
    for (int i = 0; i < N_LOOP; i++) begin
      r   = rand_word();
      adr = r % RAM_DEPTH;
      fork
        fetch_access(adr);
        data_access(r[31], adr + 2, rand_word(), mem_bus_pkg::size_word);
      join
      @(negedge clk);
    end

    repeat (4) @(negedge clk);
    errs = dut_i.chk_i.fail_cnt;
    $display("end of run at %0t ns, %0d assertion failures", $time, errs);
    if (errs == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

  // sized from the access count with slack for contention
  initial begin
    #(WDOG_CYC * CLK_NS);
    $display("run timed out after %0d cycles", WDOG_CYC);
    $display("ERRORS FOUND");
    $finish;
  end

endmodule
